// ==== common/sb_pkg.sv ====
package sb_pkg;

    // Buffer geometry
    localparam int SB_DEPTH = 8;
    localparam int SB_IDX_W = 3;
    localparam int SB_CNT_W = 4;    // Holds 0 to SB_DEPTH

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;    // One bit per byte lane
    typedef logic [31:0] tag_t;     // Larger is younger
    typedef logic [2:0]  size_t;    // funct3 of the access

    typedef logic [SB_IDX_W-1:0] idx_t;
    typedef logic [SB_CNT_W-1:0] cnt_t;

    // funct3 codes for loads and stores
    localparam size_t SIZE_B  = 3'd0;
    localparam size_t SIZE_H  = 3'd1;
    localparam size_t SIZE_W  = 3'd2;
    localparam size_t SIZE_BU = 3'd4;
    localparam size_t SIZE_HU = 3'd5;

    // AXI write master states
    typedef enum logic [1:0] {
        DRAIN_IDLE,
        DRAIN_SEND,
        DRAIN_RESP
    } drain_state_t;

endpackage

// ==== store_buffer/sb_entries.sv ====
`timescale 1ns/1ps

module sb_entries import sb_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  logic                                alloc,
    input  tag_t                                store_tag,
    input  addr_t                               store_addr,
    input  size_t                               store_size,
    input  word_t                               store_data,
    input  logic                                commit_valid,
    input  tag_t                                commit_tag,
    input  logic                                drain_pop,
    output logic                                commit_hit,
    output cnt_t                                flush_drop_count,
    output logic [SB_DEPTH-1:0]                 ent_valid,
    output logic [SB_DEPTH*$bits(tag_t)-1:0]    ent_tag,
    output logic [SB_DEPTH*$bits(addr_t)-1:0]   ent_addr,
    output logic [SB_DEPTH*$bits(word_t)-1:0]   ent_data,
    output logic [SB_DEPTH*$bits(strb_t)-1:0]   ent_strb,
    output logic                                head_committed,
    output addr_t                               head_addr,
    output word_t                               head_data,
    output strb_t                               head_strb
);

    tag_t  tag_q  [SB_DEPTH];
    addr_t addr_q [SB_DEPTH];
    word_t data_q [SB_DEPTH];
    strb_t strb_q [SB_DEPTH];

    logic [SB_DEPTH-1:0] valid_q;
    logic [SB_DEPTH-1:0] committed_q;
    logic [SB_DEPTH-1:0] valid_n;
    logic [SB_DEPTH-1:0] committed_n;
    logic [SB_DEPTH-1:0] cmatch;
    logic [SB_DEPTH-1:0] keep;
    idx_t                head;
    idx_t                tail;
    idx_t                head_n;
    idx_t                tail_n;
    cnt_t                kept_cnt;
    cnt_t                drop_cnt;
    strb_t               new_strb;
    word_t               new_data;

    // Lane placement of the incoming store
    always_comb begin
        case (store_size)
            SIZE_B: begin
                new_strb = strb_t'(4'b0001 << store_addr[1:0]);
                new_data = {4{store_data[7:0]}};
            end
            SIZE_H: begin
                new_strb = strb_t'(4'b0011 << store_addr[1:0]);
                new_data = {2{store_data[15:0]}};
            end
            default: begin
                new_strb = 4'b1111;     // SIZE_W
                new_data = store_data;
            end
        endcase
    end

    always_comb begin
        for (int e = 0; e < SB_DEPTH; e++) begin
            cmatch[e] = commit_valid && valid_q[e] && !committed_q[e]
                        && (tag_q[e] == commit_tag);
        end
    end

    assign commit_hit = |cmatch;
    assign keep       = valid_q & (committed_q | cmatch);  // Survives a flush

    always_comb begin
        kept_cnt = '0;
        drop_cnt = '0;
        for (int e = 0; e < SB_DEPTH; e++) begin
            if (keep[e])
                kept_cnt = kept_cnt + 1'b1;
            if (valid_q[e] && !keep[e])
                drop_cnt = drop_cnt + 1'b1;
        end
    end

    // A store arriving with the flush is younger and goes too
    assign flush_drop_count = flush ? drop_cnt + cnt_t'(alloc) : '0;

    always_comb begin
        valid_n     = flush ? keep : valid_q;
        committed_n = committed_q | cmatch;
        head_n      = head;
        tail_n      = tail;
        if (drain_pop) begin
            valid_n[head]     = 1'b0;
            committed_n[head] = 1'b0;
            head_n            = head + 1'b1;
        end
        if (flush) begin
            tail_n = head + idx_t'(kept_cnt);  // Committed entries form a prefix
        end else if (alloc) begin
            valid_n[tail]     = 1'b1;
            committed_n[tail] = 1'b0;
            tail_n            = tail + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q     <= '0;
            committed_q <= '0;
            head        <= '0;
            tail        <= '0;
        end else begin
            valid_q     <= valid_n;
            committed_q <= committed_n;
            head        <= head_n;
            tail        <= tail_n;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc && !flush) begin
            tag_q[tail]  <= store_tag;
            addr_q[tail] <= {store_addr[31:2], 2'b00};
            data_q[tail] <= new_data;
            strb_q[tail] <= new_strb;
        end
    end

    for (genvar e = 0; e < SB_DEPTH; e++) begin : g_flat
        assign ent_tag[e*$bits(tag_t) +: $bits(tag_t)]    = tag_q[e];
        assign ent_addr[e*$bits(addr_t) +: $bits(addr_t)] = addr_q[e];
        assign ent_data[e*$bits(word_t) +: $bits(word_t)] = data_q[e];
        assign ent_strb[e*$bits(strb_t) +: $bits(strb_t)] = strb_q[e];
    end

    assign ent_valid      = valid_q;
    assign head_committed = valid_q[head] && committed_q[head];
    assign head_addr      = addr_q[head];
    assign head_data      = data_q[head];
    assign head_strb      = strb_q[head];

    // The drain master may only retire a committed head
    a_pop_committed: assert property (@(posedge clk) disable iff (reset)
        drain_pop |-> valid_q[head] && committed_q[head]);

endmodule

// ==== store_buffer/sb_forward.sv ====
`timescale 1ns/1ps

module sb_forward import sb_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                load_req,
    input  tag_t                                load_tag,
    input  addr_t                               load_addr,
    input  size_t                               load_size,
    input  logic [SB_DEPTH-1:0]                 ent_valid,
    input  logic [SB_DEPTH*$bits(tag_t)-1:0]    ent_tag,
    input  logic [SB_DEPTH*$bits(addr_t)-1:0]   ent_addr,
    input  logic [SB_DEPTH*$bits(word_t)-1:0]   ent_data,
    input  logic [SB_DEPTH*$bits(strb_t)-1:0]   ent_strb,
    output logic                                load_done,
    output word_t                               load_data,
    output logic [1:0]                          load_cov
);

    tag_t  e_tag  [SB_DEPTH];
    word_t e_data [SB_DEPTH];
    strb_t hit    [SB_DEPTH];
    strb_t need;
    strb_t covered;
    tag_t  best_tag;
    word_t fwd_word;
    word_t shifted;
    word_t ext_word;

    always_comb begin
        case (load_size)
            SIZE_B, SIZE_BU: need = strb_t'(4'b0001 << load_addr[1:0]);
            SIZE_H, SIZE_HU: need = strb_t'(4'b0011 << load_addr[1:0]);
            default:         need = 4'b1111;
        endcase
    end

    // Older entries of the same word, masked to the lanes the load reads
    for (genvar e = 0; e < SB_DEPTH; e++) begin : g_hit
        assign e_tag[e]  = ent_tag[e*$bits(tag_t) +: $bits(tag_t)];
        assign e_data[e] = ent_data[e*$bits(word_t) +: $bits(word_t)];
        assign hit[e]    = (ent_valid[e] && (e_tag[e] < load_tag)
                           && (ent_addr[e*$bits(addr_t)+2 +: 30] == load_addr[31:2]))
                           ? ent_strb[e*$bits(strb_t) +: $bits(strb_t)] & need : '0;
    end

    // Youngest matching store wins each byte
    always_comb begin
        fwd_word = '0;
        covered  = '0;
        best_tag = '0;
        for (int b = 0; b < 4; b++) begin
            best_tag = '0;
            for (int e = 0; e < SB_DEPTH; e++) begin
                if (hit[e][b] && (!covered[b] || e_tag[e] > best_tag)) begin
                    covered[b]         = 1'b1;
                    best_tag           = e_tag[e];
                    fwd_word[8*b +: 8] = e_data[e][8*b +: 8];
                end
            end
        end
    end

    assign shifted = fwd_word >> {load_addr[1:0], 3'b000};

    always_comb begin
        case (load_size)
            SIZE_B:  ext_word = {{24{shifted[7]}}, shifted[7:0]};
            SIZE_BU: ext_word = {24'b0, shifted[7:0]};
            SIZE_H:  ext_word = {{16{shifted[15]}}, shifted[15:0]};
            SIZE_HU: ext_word = {16'b0, shifted[15:0]};
            default: ext_word = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            load_done <= 1'b0;
        else
            load_done <= load_req;
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            load_data <= ext_word;
            if (covered == need)
                load_cov <= 2'd2;   // Full
            else if (|covered)
                load_cov <= 2'd1;   // Partial
            else
                load_cov <= 2'd0;
        end
    end

endmodule

// ==== store_buffer/sb_drain_fsm.sv ====
`timescale 1ns/1ps

module sb_drain_fsm import sb_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  head_committed,
    input  addr_t head_addr,
    input  word_t head_data,
    input  strb_t head_strb,
    output logic  drain_pop,
    output logic  awvalid,
    input  logic  awready,
    output addr_t awaddr,
    output logic  wvalid,
    input  logic  wready,
    output word_t wdata,
    output strb_t wstrb,
    input  logic  bvalid,
    output logic  bready,
    input  logic  [1:0] bresp
);

    drain_state_t state;
    logic         aw_done;
    logic         w_done;

    // Channel finished once its valid is low or being accepted
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    assign bready    = (state == DRAIN_RESP);
    assign drain_pop = bready && bvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= DRAIN_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                DRAIN_IDLE: begin
                    if (head_committed) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= DRAIN_SEND;
                    end
                end
                DRAIN_SEND: begin
                    if (awvalid && awready)
                        awvalid <= 1'b0;
                    if (wvalid && wready)
                        wvalid <= 1'b0;
                    if (aw_done && w_done)
                        state <= DRAIN_RESP;
                end
                DRAIN_RESP: begin
                    if (bvalid)
                        state <= DRAIN_IDLE;    // Head pops on this edge
                end
                default: state <= DRAIN_IDLE;
            endcase
        end
    end

    // Write payload held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == DRAIN_IDLE && head_committed) begin
            awaddr <= head_addr;
            wdata  <= head_data;
            wstrb  <= head_strb;
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    // Slave must return a defined response
    a_bresp_known: assert property (@(posedge clk) disable iff (reset)
        bvalid && bready |-> !$isunknown(bresp));

endmodule

// ==== store_buffer/sb_occupancy.sv ====
`timescale 1ns/1ps

module sb_occupancy import sb_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic store_valid,
    input  logic commit_hit,
    input  logic drain_pop,
    input  cnt_t flush_drop_count,
    output logic alloc,
    output logic store_ready,
    output logic empty
);

    cnt_t total_cnt;
    cnt_t comm_cnt;

    // A slot freed this cycle is not reused until the next
    assign store_ready = (total_cnt < cnt_t'(SB_DEPTH));
    assign alloc       = store_valid && store_ready;
    assign empty       = (total_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            total_cnt <= '0;
            comm_cnt  <= '0;
        end else begin
            total_cnt <= total_cnt + cnt_t'(alloc) - cnt_t'(drain_pop) - flush_drop_count;
            comm_cnt  <= comm_cnt + cnt_t'(commit_hit) - cnt_t'(drain_pop);
        end
    end

    a_comm_le_total: assert property (@(posedge clk) disable iff (reset)
        comm_cnt <= total_cnt);

endmodule

// ==== hdl/store_unit_top.sv ====
`timescale 1ns/1ps

module store_unit_top import sb_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        store_valid,
    input  tag_t        store_tag,
    input  addr_t       store_addr,
    input  size_t       store_size,
    input  word_t       store_data,
    output logic        store_ready,
    input  logic        commit_valid,
    input  tag_t        commit_tag,
    input  logic        flush,
    input  logic        load_req,
    input  tag_t        load_tag,
    input  addr_t       load_addr,
    input  size_t       load_size,
    output logic        load_done,
    output word_t       load_data,
    output logic [1:0]  load_cov,
    output logic        empty,
    output logic        awvalid,
    input  logic        awready,
    output addr_t       awaddr,
    output logic        wvalid,
    input  logic        wready,
    output word_t       wdata,
    output strb_t       wstrb,
    input  logic        bvalid,
    output logic        bready,
    input  logic [1:0]  bresp
);

    logic                              alloc;
    logic                              commit_hit;
    logic                              drain_pop;
    cnt_t                              flush_drop_count;
    logic [SB_DEPTH-1:0]               ent_valid;
    logic [SB_DEPTH*$bits(tag_t)-1:0]  ent_tag;
    logic [SB_DEPTH*$bits(addr_t)-1:0] ent_addr;
    logic [SB_DEPTH*$bits(word_t)-1:0] ent_data;
    logic [SB_DEPTH*$bits(strb_t)-1:0] ent_strb;
    logic                              head_committed;
    addr_t                             head_addr;
    word_t                             head_data;
    strb_t                             head_strb;

    sb_occupancy u_occupancy (
        .clk, .reset, .store_valid, .commit_hit, .drain_pop,
        .flush_drop_count, .alloc, .store_ready, .empty
    );

    sb_entries u_entries (
        .clk, .reset, .flush, .alloc,
        .store_tag, .store_addr, .store_size, .store_data,
        .commit_valid, .commit_tag, .drain_pop,
        .commit_hit, .flush_drop_count,
        .ent_valid, .ent_tag, .ent_addr, .ent_data, .ent_strb,
        .head_committed, .head_addr, .head_data, .head_strb
    );

    sb_forward u_forward (
        .clk, .reset, .load_req, .load_tag, .load_addr, .load_size,
        .ent_valid, .ent_tag, .ent_addr, .ent_data, .ent_strb,
        .load_done, .load_data, .load_cov
    );

    sb_drain_fsm u_drain (
        .clk, .reset, .head_committed, .head_addr, .head_data, .head_strb,
        .drain_pop,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp
    );

endmodule

// ==== test/tb_store_unit_tasks.svh ====
task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
        abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_strb(input string name, input strb_t got, input strb_t exp);
    if (got !== exp)
        abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
        abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_cov(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
        abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

// Held until store_ready lets it through
task automatic push_store(input tag_t tag, input addr_t addr, input size_t size,
                          input word_t data);
    @(negedge clk);
    store_valid = 1'b1;
    store_tag   = tag;
    store_addr  = addr;
    store_size  = size;
    store_data  = data;
    while (!store_ready)
        @(negedge clk);
    @(negedge clk);
    store_valid = 1'b0;
endtask

task automatic commit_store(input tag_t tag);
    @(negedge clk);
    commit_valid = 1'b1;
    commit_tag   = tag;
    @(negedge clk);
    commit_valid = 1'b0;
endtask

task automatic flush_pulse();
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
endtask

task automatic issue_load(input tag_t tag, input addr_t addr, input size_t size,
                          output word_t data, output logic [1:0] cov);
    @(negedge clk);
    if (load_done)
        abort_run("load_done was high before the load was issued");
    load_req  = 1'b1;
    load_tag  = tag;
    load_addr = addr;
    load_size = size;
    @(negedge clk);
    load_req = 1'b0;
    if (!load_done)
        abort_run("load_done did not rise one cycle after the load request");
    data = load_data;
    cov  = load_cov;
endtask

// Only strobed lanes of wdata carry meaning
task automatic expect_write(input addr_t addr, input word_t data, input strb_t strb);
    word_t mask;
    word_t got;
    while (wr_addr_q.size() == 0)
        @(negedge clk);
    for (int b = 0; b < 4; b++)
        mask[8*b +: 8] = {8{strb[b]}};
    check_addr("awaddr", wr_addr_q.pop_front(), addr);
    check_strb("wstrb", wr_strb_q.pop_front(), strb);
    got = wr_data_q.pop_front();
    check_word("wdata", got & mask, data & mask);
endtask

task automatic wait_empty();
    while (!empty)
        @(negedge clk);
endtask

task automatic single_drain();
    push_store(32'd10, 32'h0000_0040, SIZE_W, 32'h1122_3344);
    commit_store(32'd10);
    expect_write(32'h0000_0040, 32'h1122_3344, 4'b1111);
    wait_empty();
    check_word("mem[0x40]", mem[16], 32'h1122_3344);
endtask

task automatic full_forward();
    word_t      d;
    logic [1:0] c;
    push_store(32'd20, 32'h0000_0080, SIZE_W, 32'hcafe_f00d);
    issue_load(32'd21, 32'h0000_0080, SIZE_W, d, c);
    check_word("load_data", d, 32'hcafe_f00d);
    check_cov("load_cov", c, 2'd2);
    commit_store(32'd20);
    expect_write(32'h0000_0080, 32'hcafe_f00d, 4'b1111);
    wait_empty();
endtask

task automatic byte_merge();
    word_t      d;
    logic [1:0] c;
    push_store(32'd30, 32'h0000_0100, SIZE_W, 32'h8877_aabb);
    push_store(32'd31, 32'h0000_0101, SIZE_B, 32'h0000_00c5);
    issue_load(32'd32, 32'h0000_0100, SIZE_H, d, c);
    check_word("load_data", d, 32'hffff_c5bb);    // Byte 1 from the SB
    check_cov("load_cov", c, 2'd2);
    issue_load(32'd33, 32'h0000_0100, SIZE_HU, d, c);
    check_word("load_data", d, 32'h0000_c5bb);
    check_cov("load_cov", c, 2'd2);
    commit_store(32'd30);
    commit_store(32'd31);
    expect_write(32'h0000_0100, 32'h8877_aabb, 4'b1111);
    expect_write(32'h0000_0100, 32'h0000_c500, 4'b0010);
    wait_empty();
    check_word("mem[0x100]", mem[64], 32'h8877_c5bb);
endtask

task automatic partial_and_older();
    word_t      d;
    logic [1:0] c;
    push_store(32'd40, 32'h0000_0203, SIZE_B, 32'h0000_005a);
    issue_load(32'd41, 32'h0000_0200, SIZE_W, d, c);
    check_word("load_data", d, 32'h5a00_0000);
    check_cov("load_cov", c, 2'd1);
    issue_load(32'd39, 32'h0000_0200, SIZE_W, d, c);  // Older than the store
    check_word("load_data", d, 32'h0000_0000);
    check_cov("load_cov", c, 2'd0);
    commit_store(32'd40);
    expect_write(32'h0000_0200, 32'h5a00_0000, 4'b1000);
    wait_empty();
endtask

task automatic flush_keeps_committed();
    word_t      d;
    logic [1:0] c;
    stall = 1'b1;
    for (int i = 0; i < 4; i++)
        push_store(tag_t'(50 + i), 32'h0000_0300 + 4 * i, SIZE_W, 32'h5000_0000 + i);
    commit_store(32'd50);
    commit_store(32'd51);
    flush_pulse();
    issue_load(32'd60, 32'h0000_0308, SIZE_W, d, c);
    check_word("load_data", d, 32'h0000_0000);
    check_cov("load_cov", c, 2'd0);
    issue_load(32'd60, 32'h0000_0300, SIZE_W, d, c);
    check_word("load_data", d, 32'h5000_0000);
    check_cov("load_cov", c, 2'd2);
    stall = 1'b0;
    expect_write(32'h0000_0300, 32'h5000_0000, 4'b1111);
    expect_write(32'h0000_0304, 32'h5000_0001, 4'b1111);
    wait_empty();
    if (wr_addr_q.size() != 0)
        abort_run("A flushed store was written to memory");
endtask

task automatic backpressure_fill();
    stall = 1'b1;
    for (int i = 0; i < 8; i++)
        push_store(tag_t'(70 + i), 32'h0000_0400 + 4 * i, SIZE_W, 32'ha000_0000 + i);
    store_valid = 1'b1;     // Ninth store must wait
    store_tag   = 32'd78;
    store_addr  = 32'h0000_0420;
    repeat (5) begin
        if (store_ready)
            abort_run("store_ready stayed high with eight stores in the buffer");
        @(negedge clk);
    end
    store_valid = 1'b0;
    for (int i = 0; i < 8; i++)
        commit_store(tag_t'(70 + i));
    stall = 1'b0;
    for (int i = 0; i < 8; i++)
        expect_write(32'h0000_0400 + 4 * i, 32'ha000_0000 + i, 4'b1111);
    wait_empty();
endtask

// ==== test/tb_store_unit.sv ====
`timescale 1ns/1ps

module tb_store_unit import sb_pkg::*; ();

    localparam int NUM_TESTS = 6;

    logic       clk;
    logic       reset;
    logic       store_valid;
    tag_t       store_tag;
    addr_t      store_addr;
    size_t      store_size;
    word_t      store_data;
    logic       store_ready;
    logic       commit_valid;
    tag_t       commit_tag;
    logic       flush;
    logic       load_req;
    tag_t       load_tag;
    addr_t      load_addr;
    size_t      load_size;
    logic       load_done;
    word_t      load_data;
    logic [1:0] load_cov;
    logic       empty;
    logic       awvalid;
    logic       awready;
    addr_t      awaddr;
    logic       wvalid;
    logic       wready;
    word_t      wdata;
    strb_t      wstrb;
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;

    // AXI slave model state
    integer seed = 83818;
    logic   stall;
    logic   stall_q;
    logic   aw_seen;
    logic   w_seen;
    logic   b_done;
    addr_t  cur_addr;
    word_t  cur_data;
    strb_t  cur_strb;
    word_t  mem [1024];
    addr_t  wr_addr_q [$];     // Completed writes in arrival order
    word_t  wr_data_q [$];
    strb_t  wr_strb_q [$];

    store_unit_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    always @(posedge clk) stall_q <= stall;

    // Handshakes decided here take effect at the next rising edge
    always @(negedge clk) begin
        if (reset) begin
            awready = 1'b0;
            wready  = 1'b0;
            bvalid  = 1'b0;
            aw_seen = 1'b0;
            w_seen  = 1'b0;
            b_done  = 1'b0;
        end else begin
            if (b_done) begin
                bvalid  = 1'b0;
                b_done  = 1'b0;
                aw_seen = 1'b0;
                w_seen  = 1'b0;
            end
            if (aw_seen && w_seen && !bvalid && !stall_q && ($random(seed) & 1))
                bvalid = 1'b1;
            if (bvalid && bready) begin
                for (int b = 0; b < 4; b++) begin
                    if (cur_strb[b])
                        mem[cur_addr[11:2]][8*b +: 8] = cur_data[8*b +: 8];
                end
                wr_addr_q.push_back(cur_addr);
                wr_data_q.push_back(cur_data);
                wr_strb_q.push_back(cur_strb);
                b_done = 1'b1;
            end
            awready = !stall_q && !aw_seen && ($random(seed) & 1);
            wready  = !stall_q && !w_seen && ($random(seed) & 1);
            if (awvalid && awready) begin
                aw_seen  = 1'b1;
                cur_addr = awaddr;
            end
            if (wvalid && wready) begin
                w_seen   = 1'b1;
                cur_data = wdata;
                cur_strb = wstrb;
            end
        end
    end

    `include "tb_store_unit_tasks.svh"

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        abort_run("Watchdog expired before the test sequence finished");
    end

    initial begin
        reset        = 1'b1;
        stall        = 1'b0;
        store_valid  = 1'b0;
        store_tag    = '0;
        store_addr   = '0;
        store_size   = SIZE_W;
        store_data   = '0;
        commit_valid = 1'b0;
        commit_tag   = '0;
        flush        = 1'b0;
        load_req     = 1'b0;
        load_tag     = '0;
        load_addr    = '0;
        load_size    = SIZE_W;
        awready      = 1'b0;
        wready       = 1'b0;
        bvalid       = 1'b0;
        bresp        = 2'b00;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (awvalid || wvalid || bready || load_done || !store_ready || !empty)
            abort_run("Outputs are not at their reset values after reset");
        single_drain();
        full_forward();
        byte_merge();
        partial_and_older();
        flush_keeps_committed();
        backpressure_fill();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== store_unit_top.f ====
+incdir+test
common/sb_pkg.sv
store_buffer/sb_entries.sv
store_buffer/sb_forward.sv
store_buffer/sb_drain_fsm.sv
store_buffer/sb_occupancy.sv
hdl/store_unit_top.sv
test/tb_store_unit.sv
